// File: bench/ExecCoreChecks.svh
`ifndef EXEC_CORE_CHECKS_SVH
`define EXEC_CORE_CHECKS_SVH

// Prints the reason and stops the run
task automatic reportFailure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "Stopping at first error");
endtask

task automatic checkAddr(input string msg, input CoreDefs::GPRAddr got,
                         input CoreDefs::GPRAddr exp);
    if (got !== exp)
        reportFailure($sformatf("Mismatch at %0t ns: %s rd got x%0d expected x%0d",
                                $time, msg, got, exp));
endtask

task automatic checkData(input string msg, input CoreDefs::Data got,
                         input CoreDefs::Data exp);
    if (got !== exp)
        reportFailure($sformatf("Mismatch at %0t ns: %s data got %h expected %h",
                                $time, msg, got, exp));
endtask

// Wait for the instruction ack to reach a level at a falling edge
task automatic waitInstAck(input logic level);
    int count;
    count = 0;
    while (o_instAck !== level)
    begin
        @(negedge clock);
        count++;
        if (count > TimeoutCycles)
            reportFailure($sformatf("Timed out waiting for instruction ack to go %0d",
                                    level));
    end
endtask

// Wait until the result req reaches a level
task automatic waitResReq(input logic level);
    int count;
    count = 0;
    while (o_resReq !== level)
    begin
        @(negedge clock);
        count++;
        if (count > TimeoutCycles)
            reportFailure($sformatf("Timed out waiting for result req to go %0d", level));
    end
endtask

`endif

// File: bench/ExecCoreTb.sv
`timescale 1ns/100ps

module ExecCoreTb;

    localparam int TimeoutCycles = 200;
    localparam int IdleLimit     = 2000;   // Sink gives up after this many quiet cycles

    typedef struct packed {
        CoreDefs::Inst     inst;
        CoreDefs::InstAddr pc;
        logic              expectRes;  // Result handshake expected
        CoreDefs::GPRAddr  rd;
    } TestVec;

    logic              clock;
    logic              i_rstN;
    logic              i_instReq;
    CoreDefs::Inst     i_inst;
    CoreDefs::InstAddr i_pc;
    logic              i_resAck;
    logic              o_instAck;
    logic              o_resReq;
    CoreDefs::GPRAddr  o_resAddr;
    CoreDefs::Data     o_resData;

    TestVec             table_[$];
    CoreDefs::Data      modelRegs [32];
    CoreDefs::WbResult  expected [$];
    int                 expectedTotal;
    int                 resultCount;
    integer             seed;
    logic               done;
    logic               prevBusy;
    logic               prevAck;

    `include "ExecCoreChecks.svh"

    ExecCore u_dut (
        .i_clock (clock), .i_rstN (i_rstN), .i_instReq (i_instReq),
        .i_inst (i_inst), .i_pc (i_pc), .i_resAck (i_resAck),
        .o_instAck (o_instAck), .o_resReq (o_resReq),
        .o_resAddr (o_resAddr), .o_resData (o_resData)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic CoreDefs::Inst encR(logic [6:0] f7, CoreDefs::GPRAddr rs2,
                                           CoreDefs::GPRAddr rs1, logic [2:0] f3,
                                           CoreDefs::GPRAddr rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic CoreDefs::Inst encI(logic [11:0] imm, CoreDefs::GPRAddr rs1,
                                           logic [2:0] f3, CoreDefs::GPRAddr rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic CoreDefs::Inst encU(logic [19:0] imm, CoreDefs::GPRAddr rd,
                                           logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    task automatic addVec(CoreDefs::Inst inst, CoreDefs::InstAddr pc, logic res,
                          CoreDefs::GPRAddr rd);
        table_.push_back({inst, pc, res, rd});
    endtask

    task automatic loadTable();
        addVec(encU(20'h12345, 1, 7'b0110111), 32'h0, 1, 1);     // LUI seeds x1
        addVec(encI(12'h678, 1, 3'd0, 1), 32'h4, 1, 1);          // Dependent ADDI
        addVec(encI(-12'sd5, 0, 3'd0, 2), 32'h8, 1, 2);          // Negative imm
        addVec(encI(12'd7, 0, 3'd0, 3), 32'hC, 1, 3);
        addVec(encR(7'h00, 2, 1, 3'd0, 4), 32'h10, 1, 4);        // ADD
        addVec(encR(7'h20, 2, 1, 3'd0, 5), 32'h14, 1, 5);        // SUB
        addVec(encR(7'h00, 3, 2, 3'd1, 6), 32'h18, 1, 6);        // SLL
        addVec(encR(7'h00, 3, 2, 3'd2, 7), 32'h1C, 1, 7);        // SLT
        addVec(encR(7'h00, 3, 2, 3'd3, 8), 32'h20, 1, 8);        // SLTU
        addVec(encR(7'h00, 2, 1, 3'd4, 9), 32'h24, 1, 9);        // XOR
        addVec(encR(7'h00, 3, 2, 3'd5, 10), 32'h28, 1, 10);      // SRL
        addVec(encR(7'h20, 3, 2, 3'd5, 11), 32'h2C, 1, 11);      // SRA
        addVec(encR(7'h00, 3, 1, 3'd6, 12), 32'h30, 1, 12);      // OR
        addVec(encR(7'h00, 2, 1, 3'd7, 13), 32'h34, 1, 13);      // AND
        addVec(encI(-12'sd3, 2, 3'd2, 14), 32'h38, 1, 14);       // SLTI
        addVec(encI(-12'sd1, 3, 3'd3, 15), 32'h3C, 1, 15);       // SLTIU
        addVec(encI(-12'sd1, 1, 3'd4, 16), 32'h40, 1, 16);       // XORI
        addVec(encI(12'h0F0, 3, 3'd6, 17), 32'h44, 1, 17);       // ORI
        addVec(encI(12'h0FF, 1, 3'd7, 18), 32'h48, 1, 18);       // ANDI
        addVec(encI({7'h00, 5'd4}, 1, 3'd1, 19), 32'h4C, 1, 19); // SLLI
        addVec(encI({7'h00, 5'd28}, 2, 3'd5, 20), 32'h50, 1, 20);
        addVec(encI({7'h20, 5'd1}, 2, 3'd5, 21), 32'h54, 1, 21); // SRAI
        addVec(encU(20'h00001, 22, 7'b0010111), 32'h100, 1, 22); // AUIPC
        addVec(encU(20'hFFFFF, 23, 7'b0010111), 32'h2000, 1, 23);
        addVec(encI(12'd100, 0, 3'd0, 24), 32'h58, 1, 24);
        addVec(encI(12'd1, 24, 3'd0, 24), 32'h5C, 1, 24);        // rs1 is previous rd
        addVec(encR(7'h00, 24, 24, 3'd0, 25), 32'h60, 1, 25);
        addVec(encI(12'd5, 1, 3'd0, 0), 32'h64, 0, 0);           // Write to x0
        addVec(encR(7'h00, 1, 0, 3'd0, 26), 32'h68, 1, 26);      // x0 still zero
        addVec(encR(7'h20, 1, 2, 3'd1, 28), 32'h6C, 0, 28);      // Illegal funct7
        addVec(32'hFFFF_FFFF, 32'h70, 0, 31);                    // Unknown opcode
        addVec(encI({7'h20, 5'd3}, 1, 3'd1, 29), 32'h74, 0, 29); // Illegal SLLI
        addVec(encR(7'h00, 0, 0, 3'd0, 27), 32'h78, 1, 27);
    endtask

    // RV32I reference for OP, OP-IMM, LUI and AUIPC; returns 1 for a legal word
    function automatic logic modelExec(CoreDefs::Inst w, CoreDefs::InstAddr pc,
                                       output CoreDefs::Data val);
        logic [6:0]    f7;
        logic [2:0]    f3;
        logic          alt;
        logic          isImm;
        CoreDefs::Data a;
        CoreDefs::Data b;
        f7    = w[31:25];
        f3    = w[14:12];
        a     = modelRegs[w[19:15]];
        isImm = (w[6:0] == 7'b0010011);
        b     = isImm ? {{20{w[31]}}, w[31:20]} : modelRegs[w[24:20]];
        val   = '0;
        if (w[6:0] == 7'b0110111 || w[6:0] == 7'b0010111)
        begin
            val = {w[31:12], 12'b0} + ((w[6:0] == 7'b0010111) ? pc : 32'b0);
            return 1'b1;
        end
        if (w[6:0] != 7'b0110011 && !isImm)
            return 1'b0;
        if (isImm && f3 == 3'd1 && f7 != 7'h00)
            return 1'b0;
        if ((!isImm || f3 == 3'd5) && f7 != 7'h00 &&
            !(f7 == 7'h20 && (f3 == 3'd5 || (!isImm && f3 == 3'd0))))
            return 1'b0;
        alt = f7[5] && (f3 == 3'd5 || !isImm);
        case (f3)
            3'd0: val = alt ? a - b : a + b;
            3'd1: val = a << b[4:0];
            3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: val = (a < b) ? 32'd1 : 32'd0;
            3'd4: val = a ^ b;
            3'd5: val = alt ? CoreDefs::Data'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: val = a | b;
            default: val = a & b;
        endcase
        return 1'b1;
    endfunction

    // Four-phase master on the instruction port
    task automatic issueInst(TestVec vec);
        @(posedge clock);
        i_instReq <= 1'b1;
        i_inst    <= vec.inst;
        i_pc      <= vec.pc;
        @(negedge clock);
        waitInstAck(1'b1);
        @(posedge clock);
        i_instReq <= 1'b0;
        @(negedge clock);
        waitInstAck(1'b0);
    endtask

    // No new instruction may be acked while the result port is busy
    always @(negedge clock)
    begin
        if (i_rstN && o_instAck && !prevAck && prevBusy)
            reportFailure("Instruction acked while a result was still pending");
        prevAck  <= o_instAck;
        prevBusy <= o_resReq || i_resAck;
    end

    // Result sink with random ack delay
    initial
    begin
        int idle;
        int delay;
        CoreDefs::WbResult exp;
        idle = 0;
        @(posedge i_rstN);
        while (!done)
        begin
            @(negedge clock);
            if (o_resReq)
            begin
                idle = 0;
                if (expected.size() == 0)
                    reportFailure("Result request raised with no result expected");
                exp = expected.pop_front();
                checkAddr($sformatf("result %0d", resultCount), o_resAddr, exp.regWrAddr);
                checkData($sformatf("result %0d", resultCount), o_resData, exp.data);
                delay = $unsigned($random(seed)) % 5;
                repeat (delay) @(posedge clock);
                @(posedge clock);
                i_resAck <= 1'b1;
                @(negedge clock);
                waitResReq(1'b0);
                @(posedge clock);
                i_resAck <= 1'b0;
                resultCount++;
            end
            else
            begin
                idle++;
                if (idle > IdleLimit)
                    reportFailure("Result sink saw no request for too long");
            end
        end
    end

    initial
    begin
        CoreDefs::Data val;
        logic          legal;
        int            count;
        seed          = 26;
        i_rstN        = 1'b0;
        i_instReq     = 1'b0;
        i_inst        = '0;
        i_pc          = '0;
        i_resAck      = 1'b0;
        done          = 1'b0;
        prevAck       = 1'b0;
        prevBusy      = 1'b0;
        resultCount   = 0;
        expectedTotal = 0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        loadTable();
        repeat (4) @(posedge clock);
        i_rstN <= 1'b1;

        foreach (table_[i])
        begin
            legal = modelExec(table_[i].inst, table_[i].pc, val);
            if ((legal && table_[i].rd != 0) !== table_[i].expectRes)
                reportFailure($sformatf("Vector %0d disagrees with the reference model", i));
            if (table_[i].expectRes)
            begin
                modelRegs[table_[i].rd] = val;    // In-order update
                expected.push_back({table_[i].rd, val});
                expectedTotal++;
            end
            issueInst(table_[i]);
        end

        count = 0;
        while (resultCount < expectedTotal)
        begin
            @(negedge clock);
            count++;
            if (count > TimeoutCycles)
                reportFailure("Timed out waiting for the last results");
        end
        done = 1'b1;
        $display("all tests passed");
        $finish;
    end

endmodule

// File: logic/AluUnit.sv
`timescale 1ns/100ps

module AluUnit (
    input  CoreDefs::AluOp i_aluControl,
    input  CoreDefs::Data  i_operandA,
    input  CoreDefs::Data  i_operandB,
    output CoreDefs::Data  o_result
);

    logic [4:0] shamt;

    assign shamt = i_operandB[4:0];               // RV32 shift amount

    always_comb
    begin
        case (i_aluControl)
            CoreDefs::AluAdd:  o_result = i_operandA + i_operandB;
            CoreDefs::AluSub:  o_result = i_operandA - i_operandB;
            CoreDefs::AluSll:  o_result = i_operandA << shamt;
            CoreDefs::AluSlt:  o_result = {31'b0, $signed(i_operandA) < $signed(i_operandB)};
            CoreDefs::AluSltu: o_result = {31'b0, i_operandA < i_operandB};
            CoreDefs::AluXor:  o_result = i_operandA ^ i_operandB;
            CoreDefs::AluSrl:  o_result = i_operandA >> shamt;
            CoreDefs::AluSra:  o_result = $signed(i_operandA) >>> shamt;
            CoreDefs::AluOr:   o_result = i_operandA | i_operandB;
            CoreDefs::AluAnd:  o_result = i_operandA & i_operandB;
            default:           o_result = '0;
        endcase
    end

endmodule

// File: logic/CoreDefs.sv
package CoreDefs;

    typedef logic [31:0] Data;      // Register or ALU value
    typedef logic [31:0] InstAddr;  // Program counter
    typedef logic [31:0] Inst;      // Raw instruction word
    typedef logic [4:0]  GPRAddr;   // Register index x0..x31

    // Encoded as {funct7[5], funct3} so OP and the shifts map directly
    typedef enum logic [3:0] {
        AluAdd  = 4'b0000,
        AluSub  = 4'b1000,
        AluSll  = 4'b0001,
        AluSlt  = 4'b0010,
        AluSltu = 4'b0011,
        AluXor  = 4'b0100,
        AluSrl  = 4'b0101,
        AluSra  = 4'b1101,
        AluOr   = 4'b0110,
        AluAnd  = 4'b0111
    } AluOp;

    typedef enum logic [1:0] {
        ASelRs1,                    // Register RS1
        ASelPc,                     // PC, for AUIPC
        ASelZero                    // Zero, for LUI
    } DataASel;

    typedef enum logic {
        BSelRs2,                    // Register RS2
        BSelImm                     // Decoded immediate
    } DataBSel;

    typedef struct packed {
        logic    isValid;           // Slot holds a real instruction
        InstAddr pc;                // PC of the instruction
        Data     instIMM;           // Sign-extended or upper immediate
        GPRAddr  rs1Addr;           // Source register 1
        GPRAddr  rs2Addr;           // Source register 2
        Data     dataRS1;           // RS1 value read at decode
        Data     dataRS2;           // RS2 value read at decode
        GPRAddr  regWrAddr;         // Destination register
        logic    regWrEnable;       // Instruction writes rd
        DataASel operandASel;       // Operand A source
        DataBSel operandBSel;       // Operand B source
        AluOp    aluControl;        // ALU operation
    } DecodedInst;

    typedef struct packed {
        GPRAddr regWrAddr;          // Destination register
        Data    data;               // Value to write
    } WbResult;

    typedef enum logic {
        AcceptIdle,                 // Waiting for request
        AcceptAckHigh               // Ack raised, waiting for req low
    } AcceptState;

    typedef enum logic [1:0] {
        ResultIdle,                 // Nothing pending
        ResultReqHigh,              // Req raised, waiting for ack
        ResultWaitAckLow            // Written, waiting for ack low
    } ResultState;

endpackage

// File: logic/ExecCore.sv
`timescale 1ns/100ps

module ExecCore (
    input  logic              i_clock,
    input  logic              i_rstN,
    input  logic              i_instReq,    // Instruction port, slave side
    input  CoreDefs::Inst     i_inst,
    input  CoreDefs::InstAddr i_pc,
    input  logic              i_resAck,     // Result port, master side
    output logic              o_instAck,
    output logic              o_resReq,
    output CoreDefs::GPRAddr  o_resAddr,
    output CoreDefs::Data     o_resData
);

    logic                 accept;
    logic                 stall;
    CoreDefs::Inst        inst;
    CoreDefs::InstAddr    pc;
    CoreDefs::GPRAddr     rs1Addr;
    CoreDefs::GPRAddr     rs2Addr;
    CoreDefs::Data        rdDataA;
    CoreDefs::Data        rdDataB;
    CoreDefs::DecodedInst decoded;
    CoreDefs::DecodedInst decodedEx;
    CoreDefs::WbResult    exResult;
    logic                 exResultValid;
    CoreDefs::WbResult    pending;
    logic                 pendingValid;
    logic                 wrEnable;
    CoreDefs::GPRAddr     wrAddr;
    CoreDefs::Data        wrData;

    InstAccept u_accept (
        .i_clock (i_clock), .i_rstN (i_rstN), .i_instReq (i_instReq),
        .i_inst (i_inst), .i_pc (i_pc), .i_stall (stall),
        .o_instAck (o_instAck), .o_accept (accept), .o_inst (inst), .o_pc (pc)
    );

    InstDecoder u_decoder (
        .i_accept (accept), .i_inst (inst), .i_pc (pc),
        .i_dataRS1 (rdDataA), .i_dataRS2 (rdDataB),
        .o_rs1Addr (rs1Addr), .o_rs2Addr (rs2Addr), .o_decoded (decoded)
    );

    RegFile u_regFile (
        .i_clock (i_clock), .i_rstN (i_rstN),
        .i_rdAddrA (rs1Addr), .i_rdAddrB (rs2Addr),
        .i_wrEnable (wrEnable), .i_wrAddr (wrAddr), .i_wrData (wrData),
        .o_rdDataA (rdDataA), .o_rdDataB (rdDataB)
    );

    PipelineIDEX u_idex (
        .i_clock (i_clock), .i_rstN (i_rstN), .i_stall (stall),
        .i_decoded (decoded), .o_decoded (decodedEx)
    );

    ExecStage u_exec (
        .i_decoded (decodedEx), .i_pending (pending), .i_pendingValid (pendingValid),
        .o_result (exResult), .o_resultValid (exResultValid)
    );

    ResultPort u_result (
        .i_clock (i_clock), .i_rstN (i_rstN),
        .i_result (exResult), .i_resultValid (exResultValid), .i_resAck (i_resAck),
        .o_resReq (o_resReq), .o_resAddr (o_resAddr), .o_resData (o_resData),
        .o_pending (pending), .o_pendingValid (pendingValid), .o_stall (stall),
        .o_wrEnable (wrEnable), .o_wrAddr (wrAddr), .o_wrData (wrData)
    );

endmodule

// File: logic/ExecStage.sv
`timescale 1ns/100ps

module ExecStage (
    input  CoreDefs::DecodedInst i_decoded,       // From ID/EX
    input  CoreDefs::WbResult    i_pending,       // Result not yet seen at decode
    input  logic                 i_pendingValid,
    output CoreDefs::WbResult    o_result,
    output logic                 o_resultValid
);

    CoreDefs::Data dataRS1;
    CoreDefs::Data dataRS2;
    CoreDefs::Data operandA;
    CoreDefs::Data operandB;
    CoreDefs::Data aluResult;

    // Pending rd is never x0, so a plain address match is enough
    assign dataRS1 = (i_pendingValid && i_pending.regWrAddr == i_decoded.rs1Addr) ?
                     i_pending.data : i_decoded.dataRS1;
    assign dataRS2 = (i_pendingValid && i_pending.regWrAddr == i_decoded.rs2Addr) ?
                     i_pending.data : i_decoded.dataRS2;

    always_comb
    begin
        case (i_decoded.operandASel)
            CoreDefs::ASelPc:   operandA = i_decoded.pc;
            CoreDefs::ASelZero: operandA = '0;
            default:            operandA = dataRS1;
        endcase
        operandB = (i_decoded.operandBSel == CoreDefs::BSelImm) ? i_decoded.instIMM : dataRS2;
    end

    AluUnit u_alu (
        .i_aluControl (i_decoded.aluControl),
        .i_operandA   (operandA),
        .i_operandB   (operandB),
        .o_result     (aluResult)
    );

    assign o_result.regWrAddr = i_decoded.regWrAddr;
    assign o_result.data      = aluResult;
    // x0 writes and bubbles retire without a handshake
    assign o_resultValid = i_decoded.isValid && i_decoded.regWrEnable &&
                           (i_decoded.regWrAddr != '0);

endmodule

// File: logic/InstAccept.sv
`timescale 1ns/100ps

module InstAccept (
    input  logic              i_clock,
    input  logic              i_rstN,
    input  logic              i_instReq,   // Source request
    input  CoreDefs::Inst     i_inst,      // Held stable while req is high
    input  CoreDefs::InstAddr i_pc,
    input  logic              i_stall,     // Result port busy
    output logic              o_instAck,   // Four-phase acknowledge
    output logic              o_accept,    // Capture strobe to decoder
    output CoreDefs::Inst     o_inst,
    output CoreDefs::InstAddr o_pc
);

    CoreDefs::AcceptState state;

    // Take the word only on a fresh request and with the pipeline free
    assign o_accept  = (state == CoreDefs::AcceptIdle) && i_instReq && !i_stall;
    assign o_instAck = (state == CoreDefs::AcceptAckHigh);
    assign o_inst    = i_inst;             // Decoded and loaded into ID/EX this edge
    assign o_pc      = i_pc;

    always_ff @(posedge i_clock or negedge i_rstN)
    begin
        if (!i_rstN)
            state <= CoreDefs::AcceptIdle;
        else if (o_accept)
            state <= CoreDefs::AcceptAckHigh;  // Ack rises after capture edge
        else if (o_instAck && !i_instReq)
            state <= CoreDefs::AcceptIdle;     // Req seen low, drop ack
    end

endmodule

// File: logic/InstDecoder.sv
`timescale 1ns/100ps

module InstDecoder (
    input  logic                 i_accept,    // Word captured this cycle
    input  CoreDefs::Inst        i_inst,
    input  CoreDefs::InstAddr    i_pc,
    input  CoreDefs::Data        i_dataRS1,   // Register file port A
    input  CoreDefs::Data        i_dataRS2,   // Register file port B
    output CoreDefs::GPRAddr     o_rs1Addr,
    output CoreDefs::GPRAddr     o_rs2Addr,
    output CoreDefs::DecodedInst o_decoded
);

    localparam logic [6:0] OpcodeOp    = 7'b0110011;
    localparam logic [6:0] OpcodeOpImm = 7'b0010011;
    localparam logic [6:0] OpcodeLui   = 7'b0110111;
    localparam logic [6:0] OpcodeAuipc = 7'b0010111;
    localparam logic [6:0] Funct7Base  = 7'b0000000;
    localparam logic [6:0] Funct7Alt   = 7'b0100000;  // SUB and SRA

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          legal;
    CoreDefs::Data immI;
    CoreDefs::Data immU;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign funct7    = i_inst[31:25];
    assign immI      = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immU      = {i_inst[31:12], 12'b0};
    assign o_rs1Addr = i_inst[19:15];
    assign o_rs2Addr = i_inst[24:20];

    always_comb
    begin
        legal                   = 1'b0;
        o_decoded.pc            = i_pc;
        o_decoded.instIMM       = immI;
        o_decoded.rs1Addr       = o_rs1Addr;
        o_decoded.rs2Addr       = o_rs2Addr;
        o_decoded.dataRS1       = i_dataRS1;  // Register reads merged in here
        o_decoded.dataRS2       = i_dataRS2;
        o_decoded.regWrAddr     = i_inst[11:7];
        o_decoded.regWrEnable   = 1'b1;
        o_decoded.operandASel   = CoreDefs::ASelRs1;
        o_decoded.operandBSel   = CoreDefs::BSelRs2;
        o_decoded.aluControl    = CoreDefs::AluAdd;

        case (opcode)
            OpcodeOp:
            begin
                // Alternate funct7 exists only for SUB and SRA
                legal = (funct7 == Funct7Base) ||
                        (funct7 == Funct7Alt && (funct3 == 3'b000 || funct3 == 3'b101));
                o_decoded.aluControl = CoreDefs::AluOp'({funct7[5], funct3});
            end
            OpcodeOpImm:
            begin
                o_decoded.operandBSel = CoreDefs::BSelImm;
                if (funct3 == 3'b001)
                begin
                    legal = (funct7 == Funct7Base);                 // SLLI
                    o_decoded.aluControl = CoreDefs::AluSll;
                end
                else if (funct3 == 3'b101)
                begin
                    legal = (funct7 == Funct7Base) || (funct7 == Funct7Alt);
                    o_decoded.aluControl = CoreDefs::AluOp'({funct7[5], funct3});
                end
                else
                begin
                    legal = 1'b1;                                   // Imm bit 30 ignored
                    o_decoded.aluControl = CoreDefs::AluOp'({1'b0, funct3});
                end
            end
            OpcodeLui:
            begin
                legal                 = 1'b1;
                o_decoded.instIMM     = immU;
                o_decoded.operandASel = CoreDefs::ASelZero;         // 0 + imm
                o_decoded.operandBSel = CoreDefs::BSelImm;
            end
            OpcodeAuipc:
            begin
                legal                 = 1'b1;
                o_decoded.instIMM     = immU;
                o_decoded.operandASel = CoreDefs::ASelPc;           // pc + imm
                o_decoded.operandBSel = CoreDefs::BSelImm;
            end
            default:
                o_decoded.regWrEnable = 1'b0;                       // Unsupported opcode
        endcase

        o_decoded.isValid = i_accept && legal;                      // Illegal word is a bubble
    end

endmodule

// File: logic/PipelineIDEX.sv
`timescale 1ns/100ps

module PipelineIDEX (
    input  logic                 i_clock,
    input  logic                 i_rstN,
    input  logic                 i_stall,      // Hold current contents
    input  CoreDefs::DecodedInst i_decoded,
    output CoreDefs::DecodedInst o_decoded
);

    logic                 validQ;
    CoreDefs::DecodedInst payloadQ;

    // Valid bit is the only control state of the stage
    always_ff @(posedge i_clock or negedge i_rstN)
    begin
        if (!i_rstN)
            validQ <= 1'b0;
        else if (!i_stall)
            validQ <= i_decoded.isValid;          // Bubble when nothing accepted
    end

    // Operands and control fields
    always_ff @(posedge i_clock)
    begin
        if (!i_stall)
            payloadQ <= i_decoded;
    end

    always_comb
    begin
        o_decoded         = payloadQ;
        o_decoded.isValid = validQ;               // Reset-cleared copy wins
    end

endmodule

// File: logic/RegFile.sv
`timescale 1ns/100ps

module RegFile (
    input  logic             i_clock,
    input  logic             i_rstN,
    input  CoreDefs::GPRAddr i_rdAddrA,
    input  CoreDefs::GPRAddr i_rdAddrB,
    input  logic             i_wrEnable,
    input  CoreDefs::GPRAddr i_wrAddr,
    input  CoreDefs::Data    i_wrData,
    output CoreDefs::Data    o_rdDataA,
    output CoreDefs::Data    o_rdDataB
);

    CoreDefs::Data regs [32];

    always_ff @(posedge i_clock or negedge i_rstN)
    begin
        if (!i_rstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_wrEnable && i_wrAddr != '0)
            regs[i_wrAddr] <= i_wrData;                 // x0 never written
    end

    // Asynchronous reads with x0 forced to zero
    assign o_rdDataA = (i_rdAddrA == '0) ? '0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 : regs[i_rdAddrB];

endmodule

// File: logic/ResultPort.sv
`timescale 1ns/100ps

module ResultPort (
    input  logic              i_clock,
    input  logic              i_rstN,
    input  CoreDefs::WbResult i_result,        // From execute
    input  logic              i_resultValid,
    input  logic              i_resAck,        // Sink acknowledge
    output logic              o_resReq,
    output CoreDefs::GPRAddr  o_resAddr,
    output CoreDefs::Data     o_resData,
    output CoreDefs::WbResult o_pending,       // Forwarding source
    output logic              o_pendingValid,
    output logic              o_stall,
    output logic              o_wrEnable,      // Register file write
    output CoreDefs::GPRAddr  o_wrAddr,
    output CoreDefs::Data     o_wrData
);

    CoreDefs::ResultState state;
    CoreDefs::WbResult    resultQ;

    always_ff @(posedge i_clock or negedge i_rstN)
    begin
        if (!i_rstN)
            state <= CoreDefs::ResultIdle;
        else
            case (state)
                CoreDefs::ResultIdle:
                    if (i_resultValid)
                        state <= CoreDefs::ResultReqHigh;     // Req rises after capture
                CoreDefs::ResultReqHigh:
                    if (i_resAck)
                        state <= CoreDefs::ResultWaitAckLow;  // Write and drop req
                default:
                    if (!i_resAck)
                        state <= CoreDefs::ResultIdle;
            endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (state == CoreDefs::ResultIdle && i_resultValid)
            resultQ <= i_result;
    end

    assign o_resReq   = (state == CoreDefs::ResultReqHigh);
    assign o_resAddr  = resultQ.regWrAddr;
    assign o_resData  = resultQ.data;
    assign o_wrEnable = o_resReq && i_resAck;                 // First edge with ack high
    assign o_wrAddr   = resultQ.regWrAddr;
    assign o_wrData   = resultQ.data;
    assign o_stall    = (state != CoreDefs::ResultIdle);
    assign o_pending  = resultQ;
    assign o_pendingValid = o_resReq;                         // From capture until the write

endmodule

// File: run.sh
#!/bin/sh
# Build and run the ExecCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ExecCoreTb -f tb.f -o simExecCore
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/simExecCore 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

// File: tb.f
logic/CoreDefs.sv
logic/InstAccept.sv
logic/InstDecoder.sv
logic/RegFile.sv
logic/PipelineIDEX.sv
logic/AluUnit.sv
logic/ExecStage.sv
logic/ResultPort.sv
logic/ExecCore.sv
+incdir+bench
bench/ExecCoreTb.sv
